//--- include/digit_font.svh
/* 8x8 bitmaps of the digits 0 to 9, top row first, msb is the leftmost pixel */
`ifndef DIGIT_FONT_SVH
`define DIGIT_FONT_SVH

localparam logic [7:0] DIGIT_FONT [10][8] = '{
    '{8'h3C, 8'h66, 8'h6E, 8'h7E, 8'h76, 8'h66, 8'h3C, 8'h00},
    '{8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h18, 8'h7E, 8'h00},
    '{8'h3C, 8'h66, 8'h06, 8'h1C, 8'h30, 8'h66, 8'h7E, 8'h00},
    '{8'h3C, 8'h66, 8'h06, 8'h1C, 8'h06, 8'h66, 8'h3C, 8'h00},
    '{8'h0C, 8'h1C, 8'h2C, 8'h4C, 8'h7E, 8'h0C, 8'h0C, 8'h00},
    '{8'h7E, 8'h60, 8'h7C, 8'h06, 8'h06, 8'h66, 8'h3C, 8'h00},
    '{8'h3C, 8'h66, 8'h60, 8'h7C, 8'h66, 8'h66, 8'h3C, 8'h00},
    '{8'h7E, 8'h06, 8'h0C, 8'h18, 8'h30, 8'h30, 8'h30, 8'h00},
    '{8'h3C, 8'h66, 8'h66, 8'h3C, 8'h66, 8'h66, 8'h3C, 8'h00},
    '{8'h3C, 8'h66, 8'h66, 8'h3E, 8'h06, 8'h66, 8'h3C, 8'h00}
};

`endif

//--- logic/dino_ifs.sv
/* raster_if: raster position, syncs and active window
   world_if: game tick, run state, score, obstacle positions and hit */
`timescale 1ns/1ps

interface raster_if import dino_pkg::*; ();
    coord_t hcount;
    coord_t vcount;
    // both syncs active low
    logic   line_sync;
    logic   field_sync;
    logic   active;

    modport source (output hcount, vcount, line_sync, field_sync, active);
    modport sink   (input hcount, vcount, line_sync, field_sync, active);
endinterface

interface world_if import dino_pkg::*; ();
    logic       tick;
    logic       restart;
    logic       game_over;
    // digit 4 is the ten-thousands digit
    bcd_t [4:0] score;
    coord_t     scac_x;
    coord_t     group_x;
    coord_t     lava_x;
    coord_t     ptero_x;
    logic       hit;

    modport ctrl  (output tick, restart, game_over, score, input hit);
    modport field (input tick, restart,
                   output scac_x, group_x, lava_x, ptero_x, hit);
    modport draw  (input game_over, score, scac_x, group_x, lava_x, ptero_x);
endinterface

//--- logic/dino_pkg.sv
/* widths, run state encoding, start positions, box sizes and colors
   shared by the runner game core and its raster output */
package dino_pkg;

    typedef logic [10:0] coord_t;
    typedef logic [3:0]  bcd_t;
    typedef logic [7:0]  chan_t;

    typedef enum logic [1:0] {
        RUNNING,
        OVER,
        ACKING
    } run_state_t;

    // box edges
    localparam int SPRITE_SIZE = 32;
    localparam int GROUP_WIDTH = 64;

    // obstacle lanes
    localparam coord_t GROUND_Y = 11'd248;
    localparam coord_t PTERO_Y  = 11'd200;

    // obstacle start x
    localparam coord_t SCAC_START  = 11'd1200;
    localparam coord_t PTERO_START = 11'd1400;
    localparam coord_t GROUP_START = 11'd1600;
    localparam coord_t LAVA_START  = 11'd1800;

    localparam int PASSES_PER_STEP = 12;
    localparam logic [5:0] LFSR_SEED = 6'b101011;

    // score digits, left edge of the most significant one
    localparam coord_t SCORE_X     = 11'd120;
    localparam coord_t SCORE_Y     = 11'd10;
    localparam int     DIGIT_PITCH = 16;

    // replay banner
    localparam coord_t BANNER_X = 11'd560;
    localparam coord_t BANNER_Y = 11'd200;
    localparam int     BANNER_W = 160;

    // colors as r, g, b
    localparam chan_t SKY          [3] = '{8'd135, 8'd206, 8'd235};
    localparam chan_t INK          [3] = '{8'd0, 8'd0, 8'd0};
    localparam chan_t DINO_COLOR   [3] = '{8'd46, 8'd139, 8'd87};
    localparam chan_t HAZARD_COLOR [3] = '{8'd178, 8'd34, 8'd34};
    localparam chan_t BANNER_COLOR [3] = '{8'd255, 8'd215, 8'd0};

endpackage

//--- logic/dino_run_top.sv
/* runner game top: raster timing and game world side by side,
   merged by the pixel compositor */
`timescale 1ns/1ps

module dino_run_top
    import dino_pkg::*;
#(
    parameter int TICK_CYCLES = 2_000_000,
    parameter int H_ACTIVE    = 1280,
    parameter int H_FRONT     = 32,
    parameter int H_SYNC      = 192,
    parameter int H_BACK      = 96,
    parameter int V_ACTIVE    = 480,
    parameter int V_FRONT     = 10,
    parameter int V_SYNC      = 2,
    parameter int V_BACK      = 33
) (
    input  logic        clk,
    input  logic        reset,
    input  coord_t      dino_x,
    input  coord_t      dino_y,
    input  logic        replay_req,
    output logic        replay_ack,
    output chan_t       vga_r,
    output chan_t       vga_g,
    output chan_t       vga_b,
    output logic        vga_hs,
    output logic        vga_vs,
    output logic        vga_blank_n,
    output logic        game_over,
    output logic [19:0] score_bcd
);

    raster_if raster ();
    world_if  world ();

    video_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) i_video_timing (
        .clk    (clk),
        .reset  (reset),
        .raster (raster)
    );

    run_control #(
        .TICK_CYCLES (TICK_CYCLES)
    ) i_run_control (
        .clk        (clk),
        .reset      (reset),
        .replay_req (replay_req),
        .replay_ack (replay_ack),
        .world      (world)
    );

    obstacle_field #(
        .H_ACTIVE (H_ACTIVE)
    ) i_obstacle_field (
        .clk    (clk),
        .reset  (reset),
        .dino_x (dino_x),
        .dino_y (dino_y),
        .world  (world)
    );

    pixel_compositor i_pixel_compositor (
        .clk         (clk),
        .reset       (reset),
        .dino_x      (dino_x),
        .dino_y      (dino_y),
        .raster      (raster),
        .world       (world),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n)
    );

    // board hex displays and status
    assign score_bcd = world.score;
    assign game_over = world.game_over;

endmodule

//--- logic/obstacle_field.sv
/* obstacle motion with LFSR wrap offsets, speed-up after a number
   of passes, and dino versus obstacle box collision */
`timescale 1ns/1ps

module obstacle_field
    import dino_pkg::*;
#(
    parameter int H_ACTIVE = 1280
) (
    input  logic   clk,
    input  logic   reset,
    input  coord_t dino_x,
    input  coord_t dino_y,
    world_if.field world
);

    // index order is small cactus, group, lava, pterodactyl
    localparam int N_OBS = 4;
    localparam coord_t START_X [N_OBS] = '{SCAC_START, GROUP_START, LAVA_START, PTERO_START};
    localparam coord_t LANE_Y  [N_OBS] = '{GROUND_Y, GROUND_Y, GROUND_Y, PTERO_Y};
    localparam int     BOX_W   [N_OBS] = '{SPRITE_SIZE, GROUP_WIDTH, SPRITE_SIZE, SPRITE_SIZE};

    coord_t obs_x [N_OBS];
    coord_t speed;
    logic [$clog2(PASSES_PER_STEP)-1:0] pass_cnt;
    logic [5:0]       lfsr;
    logic [N_OBS-1:0] wrap;
    logic [N_OBS-1:0] overlap;

    // each obstacle takes its own slice of the LFSR, all stay below 1800 after the wrap
    function automatic coord_t wrap_offset(input int idx, input logic [5:0] seed);
        case (idx)
            0:       return {2'b00, seed, 3'b000};
            1:       return {2'b00, ~seed, 3'b000};
            2:       return {2'b00, seed[3:0], 5'b00000};
            default: return {2'b00, seed[5:2], 5'b00000};
        endcase
    endfunction

    // dino box is SPRITE_SIZE square, obstacle boxes are SPRITE_SIZE tall
    function automatic logic boxes_overlap(input coord_t ax, input coord_t ay,
                                           input coord_t bx, input coord_t by,
                                           input int bw);
        logic [11:0] a_right;
        logic [11:0] a_bottom;
        logic [11:0] b_right;
        logic [11:0] b_bottom;
        a_right  = 12'(ax) + 12'(SPRITE_SIZE);
        a_bottom = 12'(ay) + 12'(SPRITE_SIZE);
        b_right  = 12'(bx) + 12'(bw);
        b_bottom = 12'(by) + 12'(SPRITE_SIZE);
        return (ax < b_right) && (a_right > bx) && (ay < b_bottom) && (a_bottom > by);
    endfunction

    always_comb begin
        for (int i = 0; i < N_OBS; i++) begin
            wrap[i]    = (obs_x[i] <= speed);
            overlap[i] = boxes_overlap(dino_x, dino_y, obs_x[i], LANE_Y[i], BOX_W[i]);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < N_OBS; i++) begin
                obs_x[i] <= START_X[i];
            end
            speed    <= 11'd1;
            pass_cnt <= '0;
            lfsr     <= LFSR_SEED;
        end else if (world.restart) begin
            for (int i = 0; i < N_OBS; i++) begin
                obs_x[i] <= START_X[i];
            end
            speed    <= 11'd1;
            pass_cnt <= '0;
            lfsr     <= LFSR_SEED;
        end else if (world.tick) begin
            for (int i = 0; i < N_OBS; i++) begin
                obs_x[i] <= wrap[i] ? coord_t'(H_ACTIVE) + wrap_offset(i, lfsr)
                                    : obs_x[i] - speed;
            end
            // x^6 + x^5 + 1
            lfsr <= {lfsr[4:0], lfsr[5] ^ lfsr[4]};
            // one pass per tick no matter how many obstacles wrapped
            if (|wrap) begin
                if (pass_cnt == PASSES_PER_STEP - 1) begin
                    speed    <= speed + 1'b1;
                    pass_cnt <= '0;
                end else begin
                    pass_cnt <= pass_cnt + 1'b1;
                end
            end
        end
    end

    assign world.scac_x  = obs_x[0];
    assign world.group_x = obs_x[1];
    assign world.lava_x  = obs_x[2];
    assign world.ptero_x = obs_x[3];
    assign world.hit     = |overlap;

endmodule

//--- logic/pixel_compositor.sv
/* per-pixel layering of sky, hazards, dino, score digits and replay
   banner, with color, syncs and blank registered together */
`timescale 1ns/1ps

module pixel_compositor
    import dino_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  coord_t dino_x,
    input  coord_t dino_y,
    raster_if.sink raster,
    world_if.draw  world,
    output chan_t  vga_r,
    output chan_t  vga_g,
    output chan_t  vga_b,
    output logic   vga_hs,
    output logic   vga_vs,
    output logic   vga_blank_n
);

    `include "digit_font.svh"

    chan_t      pix [3];
    logic       hazard_hit;
    logic       dino_hit;
    logic       banner_hit;
    logic       score_ink;
    coord_t     digit_x;
    logic [2:0] font_row;
    logic [2:0] font_col;

    function automatic logic in_box(input coord_t h, input coord_t v,
                                    input coord_t x, input coord_t y,
                                    input int w, input int ht);
        return (h >= x) && (12'(h) < 12'(x) + 12'(w)) &&
               (v >= y) && (12'(v) < 12'(y) + 12'(ht));
    endfunction

    always_comb begin
        hazard_hit =
            in_box(raster.hcount, raster.vcount, world.scac_x, GROUND_Y, SPRITE_SIZE, SPRITE_SIZE) ||
            in_box(raster.hcount, raster.vcount, world.group_x, GROUND_Y, GROUP_WIDTH, SPRITE_SIZE) ||
            in_box(raster.hcount, raster.vcount, world.lava_x, GROUND_Y, SPRITE_SIZE, SPRITE_SIZE) ||
            in_box(raster.hcount, raster.vcount, world.ptero_x, PTERO_Y, SPRITE_SIZE, SPRITE_SIZE);
        dino_hit   = in_box(raster.hcount, raster.vcount, dino_x, dino_y, SPRITE_SIZE, SPRITE_SIZE);
        banner_hit = in_box(raster.hcount, raster.vcount, BANNER_X, BANNER_Y, BANNER_W, SPRITE_SIZE);

        // score digits, most significant at the left
        score_ink = 1'b0;
        digit_x   = SCORE_X;
        font_row  = 3'(raster.vcount - SCORE_Y);
        font_col  = 3'd0;
        for (int i = 0; i < 5; i++) begin
            digit_x = SCORE_X + coord_t'(i * DIGIT_PITCH);
            if (in_box(raster.hcount, raster.vcount, digit_x, SCORE_Y, 8, 8)) begin
                font_col  = 3'(raster.hcount - digit_x);
                score_ink = DIGIT_FONT[world.score[4 - i]][font_row][3'd7 - font_col];
            end
        end

        if (!raster.active) begin
            pix = '{default: 8'd0};
        end else if (world.game_over) begin
            pix = SKY;
            if (banner_hit) begin
                pix = BANNER_COLOR;
            end
        end else begin
            // later layers win
            pix = SKY;
            if (hazard_hit) begin
                pix = HAZARD_COLOR;
            end
            if (dino_hit) begin
                pix = DINO_COLOR;
            end
            if (score_ink) begin
                pix = INK;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vga_r       <= '0;
            vga_g       <= '0;
            vga_b       <= '0;
            vga_hs      <= 1'b1;
            vga_vs      <= 1'b1;
            vga_blank_n <= 1'b0;
        end else begin
            vga_r       <= pix[0];
            vga_g       <= pix[1];
            vga_b       <= pix[2];
            vga_hs      <= raster.line_sync;
            vga_vs      <= raster.field_sync;
            vga_blank_n <= raster.active;
        end
    end

endmodule

//--- logic/run_control.sv
/* run state FSM, game tick timer, five digit BCD score
   and the four-phase replay handshake */
`timescale 1ns/1ps

module run_control
    import dino_pkg::*;
#(
    parameter int TICK_CYCLES = 2_000_000
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  replay_req,
    output logic  replay_ack,
    world_if.ctrl world
);

    run_state_t state;
    logic [$clog2(TICK_CYCLES)-1:0] tick_cnt;
    logic       tick_now;
    logic       replay_go;
    logic       restart_q;
    bcd_t [4:0] score_q;

    // ripple carry through the digits, 99999 rolls over to 00000
    function automatic bcd_t [4:0] bcd_inc(input bcd_t [4:0] value);
        bcd_t [4:0] result;
        logic       carry;
        result = value;
        carry  = 1'b1;
        for (int i = 0; i < 5; i++) begin
            if (carry) begin
                if (result[i] == 4'd9) begin
                    result[i] = 4'd0;
                end else begin
                    result[i] = result[i] + 4'd1;
                    carry     = 1'b0;
                end
            end
        end
        return result;
    endfunction

    assign tick_now  = (state == RUNNING) && (tick_cnt == TICK_CYCLES - 1);
    assign replay_go = (state == OVER) && replay_req;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= RUNNING;
            tick_cnt  <= '0;
            score_q   <= '0;
            restart_q <= 1'b0;
        end else begin
            restart_q <= replay_go;
            case (state)
                RUNNING: begin
                    if (tick_now) begin
                        tick_cnt <= '0;
                        score_q  <= bcd_inc(score_q);
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                    if (world.hit) begin
                        state <= OVER;
                    end
                end
                OVER: begin
                    // fresh run starts here, ack goes up with the cleared score
                    if (replay_go) begin
                        state    <= ACKING;
                        score_q  <= '0;
                        tick_cnt <= '0;
                    end
                end
                ACKING: begin
                    if (!replay_req) begin
                        state <= RUNNING;
                    end
                end
                default: state <= RUNNING;
            endcase
        end
    end

    assign world.tick      = tick_now;
    assign world.restart   = restart_q;
    assign world.game_over = (state == OVER);
    assign world.score     = score_q;
    assign replay_ack      = (state == ACKING);

endmodule

//--- logic/video_timing.sv
/* horizontal and vertical raster counters with sync and active decode */
`timescale 1ns/1ps

module video_timing
    import dino_pkg::*;
#(
    parameter int H_ACTIVE = 1280,
    parameter int H_FRONT  = 32,
    parameter int H_SYNC   = 192,
    parameter int H_BACK   = 96,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic      clk,
    input  logic      reset,
    raster_if.source  raster
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    coord_t hcount;
    coord_t vcount;
    logic   line_end;
    logic   field_end;

    assign line_end  = (hcount == coord_t'(H_TOTAL - 1));
    assign field_end = (vcount == coord_t'(V_TOTAL - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcount <= '0;
            vcount <= '0;
        end else begin
            hcount <= line_end ? '0 : hcount + 1'b1;
            // vertical steps once per line
            if (line_end) begin
                vcount <= field_end ? '0 : vcount + 1'b1;
            end
        end
    end

    assign raster.hcount     = hcount;
    assign raster.vcount     = vcount;
    assign raster.line_sync  = !((hcount >= coord_t'(H_ACTIVE + H_FRONT)) &&
                                 (hcount < coord_t'(H_ACTIVE + H_FRONT + H_SYNC)));
    assign raster.field_sync = !((vcount >= coord_t'(V_ACTIVE + V_FRONT)) &&
                                 (vcount < coord_t'(V_ACTIVE + V_FRONT + V_SYNC)));
    assign raster.active     = (hcount < coord_t'(H_ACTIVE)) && (vcount < coord_t'(V_ACTIVE));

endmodule

//--- project.f
+incdir+include
logic/dino_pkg.sv
logic/dino_ifs.sv
logic/video_timing.sv
logic/run_control.sv
logic/obstacle_field.sv
logic/pixel_compositor.sv
logic/dino_run_top.sv
tests/tb_clock.sv
tests/dino_run_props.sv
tests/tb_dino_run.sv

//--- tests/dino_run_props.sv
/* concurrent checks on score steps, replay handshake and video timing
   of the runner game top */
`timescale 1ns/1ps

module dino_run_props
    import dino_pkg::*;
#(
    parameter int H_SYNC      = 192,
    parameter int V_SYNC      = 2,
    parameter int LINE_CYCLES = 1280 + 32 + 192 + 96
) (
    input logic        clk,
    input logic        reset,
    input logic        replay_req,
    input logic        replay_ack,
    input logic        game_over,
    input logic [19:0] score_bcd,
    input chan_t       vga_r,
    input chan_t       vga_g,
    input chan_t       vga_b,
    input logic        vga_hs,
    input logic        vga_vs,
    input logic        vga_blank_n
);

    int unsigned errors = 0;
    int   hs_low;
    int   vs_low;
    int   hs_period;
    logic hs_last;
    logic hs_started;

    task automatic count_failure(input string what);
        $error("%s", what);
        errors++;
    endtask

    // -1 for any digit above 9
    function automatic int bcd_to_int(input logic [19:0] digits);
        int value;
        value = 0;
        for (int i = 4; i >= 0; i--) begin
            if (digits[i*4 +: 4] > 4'd9) begin
                return -1;
            end
            value = value * 10 + int'(digits[i*4 +: 4]);
        end
        return value;
    endfunction

    // sync low run lengths and the distance between line starts
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hs_low     <= 0;
            vs_low     <= 0;
            hs_period  <= 0;
            hs_last    <= 1'b1;
            hs_started <= 1'b0;
        end else begin
            hs_low  <= vga_hs ? 0 : hs_low + 1;
            vs_low  <= vga_vs ? 0 : vs_low + 1;
            hs_last <= vga_hs;
            if (hs_last && !vga_hs) begin
                hs_period  <= 1;
                hs_started <= 1'b1;
            end else begin
                hs_period <= hs_period + 1;
            end
        end
    end

    score_step: assert property (@(posedge clk) disable iff (reset)
        !game_over && !replay_ack && $changed(score_bcd) |->
            bcd_to_int(score_bcd) == (bcd_to_int($past(score_bcd)) + 1) % 100000)
        else count_failure("score changed by something other than one BCD step");
    score_hold: assert property (@(posedge clk) disable iff (reset)
        game_over && $past(game_over) |-> $stable(score_bcd))
        else count_failure("score moved while the game was over");
    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(replay_ack) |-> replay_req)
        else count_failure("replay_ack rose without replay_req");
    ack_fresh_run: assert property (@(posedge clk) disable iff (reset)
        $rose(replay_ack) |-> !game_over && score_bcd == 20'h0)
        else count_failure("replay_ack rose before the game was restarted");
    ack_holds: assert property (@(posedge clk) disable iff (reset)
        replay_ack && replay_req |=> replay_ack)
        else count_failure("replay_ack dropped while replay_req was still high");
    ack_release: assert property (@(posedge clk) disable iff (reset)
        !replay_req && !$past(replay_req) |-> !replay_ack)
        else count_failure("replay_ack stayed high after replay_req fell");
    hs_width: assert property (@(posedge clk) disable iff (reset)
        $rose(vga_hs) |-> hs_low == H_SYNC)
        else count_failure("horizontal sync pulse has the wrong width");
    hs_line: assert property (@(posedge clk) disable iff (reset)
        $fell(vga_hs) && hs_started |-> hs_period == LINE_CYCLES)
        else count_failure("line period is not the line total");
    vs_width: assert property (@(posedge clk) disable iff (reset)
        $rose(vga_vs) |-> vs_low == V_SYNC * LINE_CYCLES)
        else count_failure("vertical sync pulse has the wrong width");
    blank_black: assert property (@(posedge clk) disable iff (reset)
        !vga_blank_n |-> vga_r == 8'd0 && vga_g == 8'd0 && vga_b == 8'd0)
        else count_failure("color not black during blanking");

endmodule

//--- tests/tb_clock.sv
/* testbench clock and power-on reset */
`timescale 1ns/1ps

module tb_clock #(
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        // release on a falling edge, away from the DUT flops
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
    end

    // 4 ns period
    always #2 clk = ~clk;

endmodule

//--- tests/tb_dino_run.sv
/* testbench top: collision, replay handshake and safe lane phases,
   with the run timeout and the final verdict */
`timescale 1ns/1ps

module tb_dino_run
    import dino_pkg::*;
();

    localparam int TICK_CYCLES  = 4;
    localparam int LINE_CYCLES  = 1280 + 32 + 192 + 96;
    localparam int FRAME_CYCLES = LINE_CYCLES * (480 + 10 + 2 + 33);
    // every phase fits inside two frames
    localparam int TIMEOUT_CYCLES = 2 * FRAME_CYCLES;
    localparam coord_t DINO_X0 = 11'd100;
    // cactus front edge first lands inside the dino box one pixel from its right side
    localparam int HIT_TICKS   = int'(SCAC_START) - (int'(DINO_X0) + SPRITE_SIZE - 1);
    localparam int REQ_HOLD    = 3;
    localparam int SAFE_CYCLES = FRAME_CYCLES + 8 * LINE_CYCLES;
    localparam int MOVE_CYCLES = 65536;

    logic        clk;
    logic        reset;
    coord_t      dino_x;
    coord_t      dino_y;
    logic        replay_req;
    logic        replay_ack;
    chan_t       vga_r;
    chan_t       vga_g;
    chan_t       vga_b;
    logic        vga_hs;
    logic        vga_vs;
    logic        vga_blank_n;
    logic        game_over;
    logic [19:0] score_bcd;
    logic [19:0] last_score;
    int          seed;
    int          cycles = 0;
    int          advances;

    tb_clock i_clock (
        .clk   (clk),
        .reset (reset)
    );

    dino_run_top #(
        .TICK_CYCLES (TICK_CYCLES)
    ) i_dut (
        .clk         (clk),
        .reset       (reset),
        .dino_x      (dino_x),
        .dino_y      (dino_y),
        .replay_req  (replay_req),
        .replay_ack  (replay_ack),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n),
        .game_over   (game_over),
        .score_bcd   (score_bcd)
    );

    bind dino_run_top dino_run_props i_props (
        .clk         (clk),
        .reset       (reset),
        .replay_req  (replay_req),
        .replay_ack  (replay_ack),
        .game_over   (game_over),
        .score_bcd   (score_bcd),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic report_mismatch(input string test, input string expected,
                                   input string actual);
        abort_run($sformatf("error %s: expected %s, actual %s", test, expected, actual));
    endtask

    // decimal digits by repeated division, least significant in the low nibble
    function automatic logic [19:0] int_to_bcd(input int value);
        logic [19:0] digits;
        int          rest;
        rest = value % 100000;
        for (int i = 0; i < 5; i++) begin
            digits[i*4 +: 4] = 4'(rest % 10);
            rest = rest / 10;
        end
        return digits;
    endfunction

    always @(negedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout, the run did not end within %0d cycles", cycles));
        end
        if (i_dut.i_props.errors != 0) begin
            abort_run("a property check on the DUT outputs failed");
        end
    end

    initial begin
        dino_x     = DINO_X0;
        dino_y     = GROUND_Y;
        replay_req = 1'b0;
        seed       = 32'hbad3;
        wait (!reset);

        // standing in the cactus lane until the first collision
        do begin
            @(negedge clk);
        end while (!game_over);
        assert (score_bcd == int_to_bcd(HIT_TICKS))
            else report_mismatch("collision_score", $sformatf("%05h", int_to_bcd(HIT_TICKS)),
                                 $sformatf("%05h", score_bcd));

        // four-phase replay, dino moved above every lane first
        @(negedge clk);
        dino_y     = 11'd0;
        replay_req = 1'b1;
        do begin
            @(negedge clk);
        end while (!replay_ack);
        repeat (REQ_HOLD) @(negedge clk);
        replay_req = 1'b0;
        do begin
            @(negedge clk);
        end while (replay_ack);

        // safe lane for more than a frame, through wraps and speed-ups
        last_score = score_bcd;
        advances   = 0;
        for (int n = 0; n < SAFE_CYCLES; n++) begin
            if (n % MOVE_CYCLES == 0) begin
                dino_x = coord_t'($unsigned($random(seed)) % (1280 - SPRITE_SIZE));
            end
            @(negedge clk);
            assert (!game_over)
                else abort_run("game over while the dino sat above every obstacle lane");
            if (score_bcd != last_score) begin
                advances++;
            end
            last_score = score_bcd;
        end
        assert (advances >= SAFE_CYCLES / TICK_CYCLES - 1)
            else report_mismatch("safe_lane_score",
                                 $sformatf("at least %0d", SAFE_CYCLES / TICK_CYCLES - 1),
                                 $sformatf("%0d", advances));

        if (i_dut.i_props.errors == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            abort_run("a property check on the DUT outputs failed");
        end
    end

endmodule
